/* verilog/hdng_pkg.sv */
// Shared definitions for the heading controller.
// Vector types, the bus handshake states, the PID gains
// and the AXI4-Lite register map.
`default_nettype none

package hdng_pkg;

  ////////////////////
  // Vector types.
  ////////////////////
  typedef logic signed [11:0] hdng_t;    // Heading or heading error.
  typedef logic signed [9:0]  err_sat_t; // Error saturated to 10 bits.
  typedef logic signed [10:0] spd_t;     // Signed wheel speed.
  typedef logic [9:0]         frwrd_t;   // Unsigned forward speed.
  typedef logic [9:0]         duty_t;    // PWM duty and counter value.
  typedef logic [4:0]         axi_addr_t;
  typedef logic [31:0]        axi_data_t;

  // Handshake states, shared by the write and read channels.
  typedef enum logic {
    BUS_IDLE,
    BUS_RESP
  } bus_state_t;

  ////////////////////
  // PID gains.
  ////////////////////
  localparam logic signed [5:0] P_COEFF = 6'sd16;
  localparam logic signed [4:0] D_COEFF = 5'sd7;
  // Valid samples back for the derivative.
  localparam int D_DEPTH = 3;

  ////////////////////
  // Register byte offsets.
  ////////////////////
  localparam axi_addr_t REG_CTRL    = 5'h00;
  localparam axi_addr_t REG_DESIRED = 5'h04;
  localparam axi_addr_t REG_FRWRD   = 5'h08;
  localparam axi_addr_t REG_SPEED   = 5'h0C;
  localparam axi_addr_t REG_ERROR   = 5'h10;

endpackage

`default_nettype wire

/* verilog/hdng_regs.sv */
// AXI4-Lite register block.
// Holds moving, desired heading and forward speed.
// Returns the wheel speeds and the heading error on status reads.
`timescale 1ns/10ps
`default_nettype none

module hdng_regs import hdng_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  // Write address and data channels.
  input  wire axi_addr_t   awaddr,
  input  wire              awvalid,
  output logic             awready,
  input  wire axi_data_t   wdata,
  input  wire logic [3:0]  wstrb,
  input  wire              wvalid,
  output logic             wready,
  // Write response channel.
  output logic [1:0]       bresp,
  output logic             bvalid,
  input  wire              bready,
  // Read channels.
  input  wire axi_addr_t   araddr,
  input  wire              arvalid,
  output logic             arready,
  output axi_data_t        rdata,
  output logic [1:0]       rresp,
  output logic             rvalid,
  input  wire              rready,
  // Status from the datapath.
  input  wire spd_t        lft_spd,
  input  wire spd_t        rght_spd,
  input  wire hdng_t       error,
  // Control to the datapath.
  output logic             moving,
  output hdng_t            desired,
  output frwrd_t           frwrd
);

  bus_state_t wr_state;
  bus_state_t rd_state;
  logic       wr_go;
  logic       rd_go;
  axi_data_t  rd_mux;

  ////////////////////
  // Write channel.
  ////////////////////
  // Address and data are taken together, in the idle state only.
  assign wr_go   = (wr_state == BUS_IDLE) && awvalid && wvalid;
  assign awready = wr_go;
  assign wready  = wr_go;
  assign bvalid  = (wr_state == BUS_RESP);
  // Always OKAY.
  assign bresp   = 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= BUS_IDLE;
      moving   <= 1'b0;
      desired  <= '0;
      frwrd    <= '0;
    end else begin
      case (wr_state)
        BUS_IDLE: begin
          if (wr_go) begin
            wr_state <= BUS_RESP;
            // Decode, per byte lane. Read-only offsets fall through.
            case (awaddr)
              REG_CTRL: begin
                if (wstrb[0])
                  moving <= wdata[0];
              end
              REG_DESIRED: begin
                if (wstrb[0])
                  desired[7:0] <= wdata[7:0];
                if (wstrb[1])
                  desired[11:8] <= wdata[11:8];
              end
              REG_FRWRD: begin
                if (wstrb[0])
                  frwrd[7:0] <= wdata[7:0];
                if (wstrb[1])
                  frwrd[9:8] <= wdata[9:8];
              end
              default: ;
            endcase
          end
        end
        BUS_RESP: begin
          // Response held until the master takes it.
          if (bready)
            wr_state <= BUS_IDLE;
        end
        default: wr_state <= BUS_IDLE;
      endcase
    end
  end

  ////////////////////
  // Read channel.
  ////////////////////
  assign arready = (rd_state == BUS_IDLE);
  assign rd_go   = arready && arvalid;
  assign rvalid  = (rd_state == BUS_RESP);
  assign rresp   = 2'b00;

  // Read mux. Unmapped offsets read zero.
  always_comb begin
    case (araddr)
      REG_CTRL:    rd_mux = {31'h0, moving};
      REG_DESIRED: rd_mux = {20'h0, desired};
      REG_FRWRD:   rd_mux = {22'h0, frwrd};
      // Each speed sign-extended within its half word.
      REG_SPEED:   rd_mux = {{5{rght_spd[10]}}, rght_spd, {5{lft_spd[10]}}, lft_spd};
      REG_ERROR:   rd_mux = {{20{error[11]}}, error};
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rd_state <= BUS_IDLE;
    else if (rd_go)
      rd_state <= BUS_RESP;
    else if (rvalid && rready)
      rd_state <= BUS_IDLE;
  end

  // Data captured on accept, stable while rvalid waits.
  always_ff @(posedge clk) begin
    if (rd_go)
      rdata <= rd_mux;
  end

  // Write response must not drop before bready.
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* verilog/hdng_err.sv */
// Heading error stage.
// Registers desired minus measured heading for each gyro sample.
`timescale 1ns/10ps
`default_nettype none

module hdng_err import hdng_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire hdng_t hdng,
  input  wire        hdng_vld,
  input  wire hdng_t desired,
  output hdng_t      error,
  output logic       err_vld
);

  hdng_t diff;

  // 12-bit wrap on purpose.
  // A full turn is 4096 counts, so the wrapped difference
  // is the short way around the circle.
  assign diff = desired - hdng;

  ////////////////////
  // Error register.
  ////////////////////
  // Held between samples so software can read it back.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      error <= '0;
    else if (hdng_vld)
      error <= diff;
  end

  // One-cycle strobe, one per gyro sample.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      err_vld <= 1'b0;
    else
      err_vld <= hdng_vld;
  end

endmodule

`default_nettype wire

/* verilog/pid.sv */
// Saturating PID controller for heading.
// Forms the left and right wheel speeds from the error and frwrd.
`timescale 1ns/10ps
`default_nettype none

module pid import hdng_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         moving,
  input  wire         err_vld,
  input  wire hdng_t  error,
  input  wire frwrd_t frwrd,
  output spd_t        lft_spd,
  output spd_t        rght_spd
);

  // Saturated error and its delayed valid.
  err_sat_t           err_sat;
  err_sat_t           err_sat_nxt;
  logic               err_vld_d;
  // P term.
  logic signed [13:0] p_term;
  // I term.
  logic signed [14:0] err_ext;
  logic signed [14:0] int_sum;
  logic signed [14:0] integrator;
  logic               ov;
  logic signed [8:0]  i_term;
  // D term.
  err_sat_t           d_hist [D_DEPTH+1];
  logic signed [10:0] d_diff;
  logic signed [7:0]  d_diff_sat;
  logic signed [12:0] d_term;
  // Sum and wheel speeds.
  logic signed [13:0] pid_sum;
  spd_t               frwrd_ext;
  spd_t               raw_lft;
  spd_t               raw_rght;

  ////////////////////
  // Error saturation.
  ////////////////////
  // Clip the 12-bit error to the 10-bit range.
  assign err_sat_nxt = (!error[11] && |error[10:9])  ? 10'sh1FF :
                       (error[11] && !(&error[10:9])) ? 10'sh200 :
                       error[9:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_sat   <= '0;
      err_vld_d <= 1'b0;
    end else begin
      if (err_vld)
        err_sat <= err_sat_nxt;
      // Integrator and history follow one cycle later.
      err_vld_d <= err_vld;
    end
  end

  ////////////////////
  // P term.
  ////////////////////
  assign p_term = err_sat * P_COEFF;

  ////////////////////
  // I term.
  ////////////////////
  assign err_ext = {{5{err_sat[9]}}, err_sat};
  assign int_sum = integrator + err_ext;
  // Overflow only when both operands share a sign the sum lost.
  assign ov = (err_ext[14] == integrator[14]) && (int_sum[14] != integrator[14]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      integrator <= '0;
    else if (!moving)
      integrator <= '0;
    else if (err_vld_d && !ov)
      integrator <= int_sum;
  end

  // Top 9 bits only.
  assign i_term = integrator[14:6];

  ////////////////////
  // D term.
  ////////////////////
  // Slot 0 holds the newest sample, slot D_DEPTH the oldest.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i <= D_DEPTH; i++)
        d_hist[i] <= '0;
    end else if (err_vld_d) begin
      d_hist[0] <= err_sat;
      for (int i = 1; i <= D_DEPTH; i++)
        d_hist[i] <= d_hist[i-1];
    end
  end

  // Eleven bits so the raw difference never wraps.
  assign d_diff = {err_sat[9], err_sat} - {d_hist[D_DEPTH][9], d_hist[D_DEPTH]};

  assign d_diff_sat = (!d_diff[10] && |d_diff[9:7])  ? 8'sh7F :
                      (d_diff[10] && !(&d_diff[9:7])) ? 8'sh80 :
                      d_diff[7:0];

  assign d_term = d_diff_sat * D_COEFF;

  ////////////////////
  // Sum and speeds.
  ////////////////////
  // P term halved, all three sign-extended to 14 bits.
  assign pid_sum = {p_term[13], p_term[13:1]} +
                   {{5{i_term[8]}}, i_term} +
                   {d_term[12], d_term};

  assign frwrd_ext = {1'b0, frwrd};

  // Correction is the sum divided by 8.
  assign raw_lft  = moving ? frwrd_ext + pid_sum[13:3] : '0;
  assign raw_rght = moving ? frwrd_ext - pid_sum[13:3] : '0;

  // Wrapped negative under a forward push means overflow, clamp to full.
  assign lft_spd  = (!pid_sum[13] && raw_lft[10])  ? 11'sh3FF : raw_lft;
  assign rght_spd = (pid_sum[13] && raw_rght[10])  ? 11'sh3FF : raw_rght;

  // Integrator is parked at zero whenever the robot stops.
  a_int_clear: assert property (@(posedge clk) disable iff (!rst_n)
    !moving |=> (integrator == '0));

endmodule

`default_nettype wire

/* verilog/mtr_pwm.sv */
// PWM stage for both wheels.
// Shared free-running counter, registered duty and direction outputs.
`timescale 1ns/10ps
`default_nettype none

module mtr_pwm import hdng_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  wire spd_t lft_spd,
  input  wire spd_t rght_spd,
  output logic      lft_pwm,
  output logic      lft_rev,
  output logic      rght_pwm,
  output logic      rght_rev
);

  duty_t cnt;
  duty_t lft_mag;
  duty_t rght_mag;

  // Absolute speed, clamped.
  // Only -1024 lands above 1023.
  function automatic duty_t spd_mag(input spd_t spd);
    logic [10:0] mag;
    mag = spd[10] ? 11'(-spd) : 11'(spd);
    spd_mag = mag[10] ? 10'h3FF : mag[9:0];
  endfunction

  assign lft_mag  = spd_mag(lft_spd);
  assign rght_mag = spd_mag(rght_spd);

  ////////////////////
  // Period counter.
  ////////////////////
  // 1024 cycles per period.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cnt <= '0;
    else
      cnt <= cnt + 10'd1;
  end

  ////////////////////
  // Outputs.
  ////////////////////
  // High for mag counts of each period.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_pwm  <= 1'b0;
      lft_rev  <= 1'b0;
      rght_pwm <= 1'b0;
      rght_rev <= 1'b0;
    end else begin
      lft_pwm  <= (cnt < lft_mag);
      rght_pwm <= (cnt < rght_mag);
      // Direction is just the sign.
      lft_rev  <= lft_spd[10];
      rght_rev <= rght_spd[10];
    end
  end

  // A stopped wheel gets no drive pulse.
  a_lft_off: assert property (@(posedge clk) disable iff (!rst_n)
    (lft_mag == '0) |=> !lft_pwm);
  a_rght_off: assert property (@(posedge clk) disable iff (!rst_n)
    (rght_mag == '0) |=> !rght_pwm);

endmodule

`default_nettype wire

/* verilog/hdng_ctrl_top.sv */
// Heading control top level.
// Register block, error stage, PID and PWM stage.
`timescale 1ns/10ps
`default_nettype none

module hdng_ctrl_top import hdng_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  // AXI4-Lite slave.
  input  wire axi_addr_t  awaddr,
  input  wire             awvalid,
  output wire             awready,
  input  wire axi_data_t  wdata,
  input  wire logic [3:0] wstrb,
  input  wire             wvalid,
  output wire             wready,
  output wire [1:0]       bresp,
  output wire             bvalid,
  input  wire             bready,
  input  wire axi_addr_t  araddr,
  input  wire             arvalid,
  output wire             arready,
  output axi_data_t       rdata,
  output wire [1:0]       rresp,
  output wire             rvalid,
  input  wire             rready,
  // Gyro samples.
  input  wire hdng_t      hdng,
  input  wire             hdng_vld,
  // Motor drive.
  output wire             lft_pwm,
  output wire             lft_rev,
  output wire             rght_pwm,
  output wire             rght_rev
);

  // Control from software.
  logic   moving;
  hdng_t  desired;
  frwrd_t frwrd;
  // Datapath.
  hdng_t  error;
  logic   err_vld;
  spd_t   lft_spd;
  spd_t   rght_spd;

  hdng_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .lft_spd(lft_spd), .rght_spd(rght_spd), .error(error),
    .moving(moving), .desired(desired), .frwrd(frwrd)
  );

  hdng_err u_err (
    .clk(clk), .rst_n(rst_n),
    .hdng(hdng), .hdng_vld(hdng_vld), .desired(desired),
    .error(error), .err_vld(err_vld)
  );

  pid u_pid (
    .clk(clk), .rst_n(rst_n),
    .moving(moving), .err_vld(err_vld), .error(error), .frwrd(frwrd),
    .lft_spd(lft_spd), .rght_spd(rght_spd)
  );

  mtr_pwm u_pwm (
    .clk(clk), .rst_n(rst_n),
    .lft_spd(lft_spd), .rght_spd(rght_spd),
    .lft_pwm(lft_pwm), .lft_rev(lft_rev),
    .rght_pwm(rght_pwm), .rght_rev(rght_rev)
  );

endmodule

`default_nettype wire

/* dv/tb_hdng_ctrl.sv */
// Testbench for the heading controller top level.
// AXI4-Lite write and read tasks, Galois LFSR for back-pressure,
// PID reference model, compare tasks and five directed tests.
`timescale 1ns/10ps
`default_nettype none

module tb_hdng_ctrl import hdng_pkg::*; ();

  // Five tests take a few thousand cycles, so this leaves ample margin.
  localparam int MAX_CYCLES = 20000;

  logic       clk;
  logic       rst_n;
  axi_addr_t  awaddr;
  logic       awvalid;
  logic       awready;
  axi_data_t  wdata;
  logic [3:0] wstrb;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axi_addr_t  araddr;
  logic       arvalid;
  logic       arready;
  axi_data_t  rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  hdng_t      hdng;
  logic       hdng_vld;
  logic       lft_pwm;
  logic       lft_rev;
  logic       rght_pwm;
  logic       rght_rev;

  int          cycles;
  int          errors;
  int          test_err0;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr;
  // Reference model state.
  hdng_t       m_desired;
  frwrd_t      m_frwrd;
  logic        m_moving;
  hdng_t       m_err;
  int          m_integ;
  int          m_hist [D_DEPTH+1];

  hdng_ctrl_top UUT (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Watchdog.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Helpers.
  ////////////////////
  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_spd(input string name, input spd_t got, input spd_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_duty(input string name, input duty_t got, input duty_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - test_err0);
    end
  endtask

  ////////////////////
  // AXI4-Lite master.
  ////////////////////
  // Called on a falling edge and returns on one.
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input logic [3:0] strb);
    int dly;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready follows valid combinationally and settles well before the rising edge.
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    if (awready || wready)
      report_fail("awready or wready stayed high after the handshake cycle");
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Hold off bready for 0 to 3 cycles.
    rand_bits(2, dly);
    repeat (dly) begin
      if (!bvalid)
        report_fail("bvalid dropped before bready");
      @(negedge clk);
    end
    if (!bvalid)
      report_fail("no write response after the handshake");
    check_data("bresp", {30'h0, bresp}, 32'h0);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    int dly;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    data    = rdata;
    if (arready)
      report_fail("arready high while a read response is pending");
    rand_bits(2, dly);
    repeat (dly) begin
      if (!rvalid)
        report_fail("rvalid dropped before rready");
      check_data("rdata held", rdata, data);
      @(negedge clk);
    end
    if (!rvalid)
      report_fail("no read response after the handshake");
    check_data("rresp", {30'h0, rresp}, 32'h0);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic set_ctrl(input logic mv, input hdng_t des, input frwrd_t fw);
    axi_write(REG_CTRL, {31'h0, mv}, 4'hF);
    axi_write(REG_DESIRED, {20'h0, des}, 4'hF);
    axi_write(REG_FRWRD, {22'h0, fw}, 4'hF);
    m_moving  = mv;
    m_desired = des;
    m_frwrd   = fw;
    if (!mv)
      m_integ = 0;
  endtask

  ////////////////////
  // Reference model.
  ////////////////////
  // One gyro sample, then the 3-cycle latency to settled speeds.
  task automatic gyro_sample(input hdng_t h);
    hdng_t e;
    int    es;
    hdng     = h;
    hdng_vld = 1'b1;
    @(negedge clk);
    hdng_vld = 1'b0;
    repeat (3) @(negedge clk);
    // Error wraps in 12 bits, then clips to the 10-bit range.
    e     = m_desired - h;
    m_err = e;
    es    = int'(e);
    if (es > 511)
      es = 511;
    if (es < -512)
      es = -512;
    for (int i = D_DEPTH; i > 0; i--)
      m_hist[i] = m_hist[i-1];
    m_hist[0] = es;
    // 15-bit integrator holds rather than overflow.
    if (m_moving && (m_integ + es <= 16383) && (m_integ + es >= -16384))
      m_integ += es;
  endtask

  // Correction added to the left wheel and taken from the right.
  function automatic int model_corr();
    int p;
    int i;
    int dd;
    p  = (m_hist[0] * int'(P_COEFF)) >>> 1;
    i  = m_integ >>> 6;
    dd = m_hist[0] - m_hist[D_DEPTH];
    if (dd > 127)
      dd = 127;
    if (dd < -128)
      dd = -128;
    return (p + i + dd * int'(D_COEFF)) >>> 3;
  endfunction

  function automatic spd_t model_speed(input logic left);
    int v;
    if (!m_moving)
      return '0;
    v = left ? int'(m_frwrd) + model_corr() : int'(m_frwrd) - model_corr();
    // A forward push past full speed stops at full speed.
    if (v > 1023)
      v = 1023;
    return spd_t'(v);
  endfunction

  function automatic duty_t magnitude(input spd_t s);
    int a;
    a = (s < 0) ? -int'(s) : int'(s);
    return (a > 1023) ? 10'h3FF : duty_t'(a);
  endfunction

  task automatic check_speeds();
    axi_data_t d;
    spd_t      l;
    spd_t      r;
    l = model_speed(1'b1);
    r = model_speed(1'b0);
    axi_read(REG_SPEED, d);
    check_spd("lft_spd", d[10:0], l);
    check_spd("rght_spd", d[26:16], r);
    // Each half carries its speed sign-extended to 16 bits.
    check_data("REG_SPEED", d, {16'(r), 16'(l)});
    axi_read(REG_ERROR, d);
    check_data("REG_ERROR", d, 32'(m_err));
  endtask

  // Count pwm high cycles over one full counter period.
  task automatic check_drive();
    spd_t l;
    spd_t r;
    int   lh;
    int   rh;
    l  = model_speed(1'b1);
    r  = model_speed(1'b0);
    lh = 0;
    rh = 0;
    repeat (2) @(negedge clk);
    repeat (1024) begin
      @(negedge clk);
      if (lft_pwm)
        lh++;
      if (rght_pwm)
        rh++;
    end
    check_duty("lft_pwm high cycles", duty_t'(lh), magnitude(l));
    check_duty("rght_pwm high cycles", duty_t'(rh), magnitude(r));
    check_data("lft_rev", {31'h0, lft_rev}, {31'h0, l < 0});
    check_data("rght_rev", {31'h0, rght_rev}, {31'h0, r < 0});
  endtask

  ////////////////////
  // Tests.
  ////////////////////
  task automatic test_regs();
    axi_data_t d;
    test_err0 = errors;
    // awready, wready, bvalid, rvalid low and arready high out of reset.
    check_data("reset outputs", {27'h0, awready, wready, bvalid, rvalid, arready}, 32'h1);
    axi_write(REG_CTRL, 32'h0000_0001, 4'hF);
    axi_read(REG_CTRL, d);
    check_data("REG_CTRL", d, 32'h1);
    axi_write(REG_CTRL, 32'hFFFF_FFFE, 4'hF);
    axi_read(REG_CTRL, d);
    check_data("REG_CTRL", d, 32'h0);
    axi_write(REG_DESIRED, 32'hFFFF_FABC, 4'hF);
    axi_read(REG_DESIRED, d);
    check_data("REG_DESIRED", d, 32'h0000_0ABC);
    // Byte lanes one at a time.
    axi_write(REG_DESIRED, 32'h0000_0123, 4'b0001);
    axi_write(REG_DESIRED, 32'h0000_0500, 4'b0010);
    axi_write(REG_DESIRED, 32'h0000_0F00, 4'b1100);
    axi_read(REG_DESIRED, d);
    check_data("REG_DESIRED strobed", d, 32'h0000_0523);
    axi_write(REG_FRWRD, 32'h0000_03FF, 4'hF);
    axi_read(REG_FRWRD, d);
    check_data("REG_FRWRD", d, 32'h0000_03FF);
    axi_write(REG_FRWRD, 32'h0000_0155, 4'b0010);
    axi_read(REG_FRWRD, d);
    check_data("REG_FRWRD strobed", d, 32'h0000_01FF);
    // Read-only and unmapped offsets.
    axi_write(REG_SPEED, 32'h1234_5679, 4'hF);
    axi_read(REG_SPEED, d);
    check_data("REG_SPEED after write", d, 32'h0);
    axi_read(REG_CTRL, d);
    check_data("REG_CTRL after SPEED write", d, 32'h0);
    axi_read(REG_DESIRED, d);
    check_data("REG_DESIRED after SPEED write", d, 32'h0000_0523);
    axi_read(REG_FRWRD, d);
    check_data("REG_FRWRD after SPEED write", d, 32'h0000_01FF);
    axi_read(5'h14, d);
    check_data("unmapped 0x14", d, 32'h0);
    m_moving  = 1'b0;
    m_desired = 12'h523;
    m_frwrd   = 10'h1FF;
    end_test("register access");
  endtask

  task automatic test_idle();
    int high;
    test_err0 = errors;
    set_ctrl(1'b0, 12'h100, 10'h180);
    gyro_sample(12'h100);
    gyro_sample(12'h3A0);
    gyro_sample(12'hC00);
    gyro_sample(12'h0F8);
    check_speeds();
    high = 0;
    repeat (1024) begin
      @(negedge clk);
      if (lft_pwm || rght_pwm)
        high++;
    end
    if (high != 0)
      report_fail("pwm output went high while moving is low");
    end_test("idle");
  endtask

  task automatic test_straight();
    axi_data_t d;
    test_err0 = errors;
    set_ctrl(1'b1, 12'h7F0, 10'h155);
    // Flush the derivative history with zero-error samples.
    repeat (D_DEPTH + 1) begin
      gyro_sample(12'h7F0);
      check_speeds();
    end
    axi_read(REG_SPEED, d);
    check_spd("lft_spd straight", d[10:0], 11'h155);
    check_spd("rght_spd straight", d[26:16], 11'h155);
    end_test("straight line");
  endtask

  task automatic test_closed_loop();
    int v;
    test_err0 = errors;
    set_ctrl(1'b1, 12'h200, 10'h200);
    for (int n = 0; n < 40; n++) begin
      if (n == 20) begin
        // Stop and restart so both integrators clear.
        axi_write(REG_CTRL, 32'h0, 4'hF);
        m_moving = 1'b0;
        m_integ  = 0;
        axi_write(REG_CTRL, 32'h1, 4'hF);
        m_moving = 1'b1;
      end
      rand_bits(12, v);
      gyro_sample(hdng_t'(v));
      check_speeds();
    end
    end_test("closed loop");
  endtask

  task automatic test_drive();
    test_err0 = errors;
    set_ctrl(1'b1, 12'h000, 10'd300);
    repeat (D_DEPTH + 1) gyro_sample(12'h000);
    check_drive();
    // Error of +400 drives the right wheel backward.
    gyro_sample(12'hE70);
    check_drive();
    // Error of -400 drives the left wheel backward.
    gyro_sample(12'h190);
    check_drive();
    end_test("motor drive");
  endtask

  initial begin
    rst_n        = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    hdng         = '0;
    hdng_vld     = 1'b0;
    lfsr         = 32'h42f1_05c0;
    cycles       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    m_desired    = '0;
    m_frwrd      = '0;
    m_moving     = 1'b0;
    m_err        = '0;
    m_integ      = 0;
    for (int i = 0; i <= D_DEPTH; i++)
      m_hist[i] = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_regs();
    test_idle();
    test_straight();
    test_closed_loop();
    test_drive();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
verilog/hdng_pkg.sv
verilog/hdng_regs.sv
verilog/hdng_err.sv
verilog/pid.sv
verilog/mtr_pwm.sv
verilog/hdng_ctrl_top.sv
dv/tb_hdng_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hdng_ctrl -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }
